//--- include/mdll_config.svh
`ifndef MDLL_CONFIG_SVH
`define MDLL_CONFIG_SVH

// ------------------------------
// jitter monitor configuration
// ------------------------------

// width of window timer and early counter
// window length is 2**JM_CNT_W monitor cycles, 6 -> 64 cycles
// also sets the width of jm_cdf_out
`define JM_CNT_W 6

// fallback phase for undefined select codes (5..7)
// expands to a jm_clk_sel_e literal, so the user must import mdll_pkg
`define JM_SEL_DEFAULT sel_osc_180

`endif

//--- src/mdll_pkg.sv
package mdll_pkg;

	// ------------------------------
	// clock select opcodes
	// ------------------------------

	// codes 5..7 left undefined on purpose
	// the sampler maps them to `JM_SEL_DEFAULT
	typedef enum logic [2:0] {
		sel_osc_0   = 3'd0, // I phase
		sel_osc_90  = 3'd1, // Q phase
		sel_osc_180 = 3'd2, // /I phase
		sel_osc_270 = 3'd3, // /Q phase
		sel_clk_fb  = 3'd4  // divided feedback clock
	} jm_clk_sel_e;

endpackage

//--- src/mdll_jm_sampler.sv
`timescale 1ns/1ps

`include "mdll_config.svh"

module mdll_jm_sampler import mdll_pkg::*; (
	input  logic        clk_monp,      // monitor clock, phase swept from outside
	input  logic        en_monitor,    // active low clear
	input  jm_clk_sel_e jm_sel_clk,    // which clock is under test
	input  logic        jm_bb_out_pol, // 1 keeps early as is, 0 inverts
	input  logic        osc_0,         // I
	input  logic        osc_90,        // Q
	input  logic        osc_180,       // /I
	input  logic        osc_270,       // /Q
	input  logic        clk_fb_mon,    // divided feedback clock
	output logic        inc_cntr       // one cycle level, count this cycle
);

	// ------------------------------
	// signals
	// ------------------------------

	jm_clk_sel_e sel_eff; // select after fallback decode
	logic        clk_ut;  // clock under test
	logic        early;   // clk_ut after polarity control

	// ------------------------------
	// select decode
	// ------------------------------

	// legal codes pass through, anything else goes to the default phase
	always_comb begin
		case (jm_sel_clk)
			sel_osc_0,
			sel_osc_90,
			sel_osc_180,
			sel_osc_270,
			sel_clk_fb: sel_eff = jm_sel_clk;
			default:    sel_eff = `JM_SEL_DEFAULT; // codes 5..7
		endcase
	end

	// ------------------------------
	// clock under test mux
	// ------------------------------

	always_comb begin
		case (sel_eff)
			sel_osc_0:   clk_ut = osc_0;
			sel_osc_90:  clk_ut = osc_90;
			sel_osc_180: clk_ut = osc_180;
			sel_osc_270: clk_ut = osc_270;
			sel_clk_fb:  clk_ut = clk_fb_mon;
			default:     clk_ut = 1'b0; // unreachable after decode
		endcase
	end

	// ------------------------------
	// polarity control
	// ------------------------------

	// a high level at the clk_monp edge means the clock under test was
	// already up, i.e. its edge came early
	// pol 0 turns this into a "late" count for the opposite cdf slope
	assign early = jm_bb_out_pol ? clk_ut : ~clk_ut;

	// ------------------------------
	// bang-bang sampling flop
	// ------------------------------

	// single flop stands in for the differential sampler
	// result shows one cycle after the sampled edge
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			inc_cntr <= 1'b0; // nothing counted while disabled
		end else begin
			inc_cntr <= early;
		end
	end

endmodule

//--- src/mdll_jm_counter.sv
`timescale 1ns/1ps

`include "mdll_config.svh"

module mdll_jm_counter (
	input  logic                 clk_monp,     // monitor clock
	input  logic                 en_monitor,   // active low clear
	input  logic                 inc_cntr,     // early decision from sampler
	output logic [`JM_CNT_W-1:0] jm_cdf_out,   // early count of last window
	output logic                 jm_cdf_valid  // one cycle strobe on update
);

	localparam int CNT_W = `JM_CNT_W; // window = 2**CNT_W cycles

	// ------------------------------
	// signals
	// ------------------------------

	logic [CNT_W-1:0] win_tmr;   // free running window timer
	logic [CNT_W-1:0] early_cnt; // early decisions so far in window
	logic [CNT_W-1:0] early_nxt; // count including this cycle
	logic             win_end;   // last cycle of window
	logic             cnt_full;  // counter at all-ones

	// ------------------------------
	// window timer
	// ------------------------------

	// counts 0 .. all-ones and wraps, no load
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			win_tmr <= '0;
		end else begin
			win_tmr <= win_tmr + 1'b1; // wraps at all-ones
		end
	end

	assign win_end = &win_tmr;

	// ------------------------------
	// saturating early counter
	// ------------------------------

	assign cnt_full = &early_cnt;

	// hold at all-ones, so a window that is early every cycle
	// (2**CNT_W hits) still reports all-ones
	always_comb begin
		if (inc_cntr && !cnt_full) begin
			early_nxt = early_cnt + 1'b1;
		end else begin
			early_nxt = early_cnt;
		end
	end

	// clears at window end, the last cycle's hit goes to the result
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			early_cnt <= '0;
		end else if (win_end) begin
			early_cnt <= '0; // fresh window
		end else begin
			early_cnt <= early_nxt;
		end
	end

	// ------------------------------
	// result register and strobe
	// ------------------------------

	// loads once per window; first strobe 2**CNT_W edges after
	// en_monitor goes high
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			jm_cdf_out   <= '0;
			jm_cdf_valid <= 1'b0;
		end else begin
			jm_cdf_valid <= win_end; // single cycle, timer only all-ones once
			if (win_end) begin
				jm_cdf_out <= early_nxt; // includes this cycle's inc_cntr
			end
		end
	end

endmodule

//--- src/mdll_jmeas.sv
`timescale 1ns/1ps

`include "mdll_config.svh"

module mdll_jmeas import mdll_pkg::*; (
	input  logic                 clk_monp,      // monitor clock, swept outside
	input  logic                 en_monitor,    // active low, low clears all
	input  jm_clk_sel_e          jm_sel_clk,    // clock under test select
	input  logic                 jm_bb_out_pol, // early polarity
	input  logic                 osc_0,         // I
	input  logic                 osc_90,        // Q
	input  logic                 osc_180,       // /I
	input  logic                 osc_270,       // /Q
	input  logic                 clk_fb_mon,    // divided feedback clock
	output logic                 jm_clk_fb_out, // feedback clock to the scope
	output logic [`JM_CNT_W-1:0] jm_cdf_out,    // cdf point of last window
	output logic                 jm_cdf_valid   // strobe on each update
);

	// ------------------------------
	// internal wires
	// ------------------------------

	logic inc_cntr; // sampler -> counter, one bit per cycle

	// ------------------------------
	// feedthrough
	// ------------------------------

	// straight wire, no register, so the scope sees the real edge
	assign jm_clk_fb_out = clk_fb_mon;

	// ------------------------------
	// input side
	// ------------------------------

	mdll_jm_sampler i_sampler (
		.clk_monp      (clk_monp),
		.en_monitor    (en_monitor),
		.jm_sel_clk    (jm_sel_clk),
		.jm_bb_out_pol (jm_bb_out_pol),
		.osc_0         (osc_0),
		.osc_90        (osc_90),
		.osc_180       (osc_180),
		.osc_270       (osc_270),
		.clk_fb_mon    (clk_fb_mon),
		.inc_cntr      (inc_cntr)
	);

	// ------------------------------
	// window counting
	// ------------------------------

	// one cycle sample latency, so an input change may straddle a window;
	// the second strobe after a change is the clean one
	mdll_jm_counter i_counter (
		.clk_monp     (clk_monp),
		.en_monitor   (en_monitor),
		.inc_cntr     (inc_cntr),
		.jm_cdf_out   (jm_cdf_out),
		.jm_cdf_valid (jm_cdf_valid)
	);

endmodule

//--- verif/jmeas_checker.sv
`timescale 1ns/1ps

`include "mdll_config.svh"

module jmeas_checker (
	input  logic                 clk_monp,      // same clock as the DUT
	input  logic                 en_monitor,    // active low clear, as driven
	input  logic                 clk_fb_mon,    // feedback clock into DUT
	input  logic                 jm_clk_fb_out, // feedthrough from DUT
	input  logic [`JM_CNT_W-1:0] jm_cdf_out,    // window result
	input  logic                 jm_cdf_valid,  // update strobe
	input  logic                 settled,       // testbench says next strobe counts
	input  logic [`JM_CNT_W-1:0] exp_cnt,       // expected window count
	input  int                   tol,           // allowed distance from exp_cnt
	output int                   err_cnt,       // errors seen so far
	output int                   n_checked      // value checks done
);

	localparam int WIN = 1 << `JM_CNT_W; // strobe period in cycles

	// ------------------------------
	// state
	// ------------------------------

	int   errs     = 0;
	int   checks   = 0;
	int   gap      = 0;    // cycles since last strobe or release
	logic run      = 1'b0; // en_monitor high and reference taken
	logic clk_seen = 1'b0; // flops have had one edge to settle
	logic valid_q  = 1'b0; // strobe one cycle ago

	assign err_cnt   = errs;
	assign n_checked = checks;

	// ------------------------------
	// compare at the rising edge
	// ------------------------------

	// flop outputs read here are the values from before this edge
	always @(posedge clk_monp) begin : watch
		int diff;
		// feedthrough is a plain wire
		if (jm_clk_fb_out !== clk_fb_mon) begin
			$display("ERR jm_clk_fb_out exp %h got %h", clk_fb_mon, jm_clk_fb_out);
			errs++;
		end
		if (!en_monitor) begin
			// async clear, outputs must already be zero
			if (clk_seen && (jm_cdf_out !== '0)) begin
				$display("ERR jm_cdf_out exp %h got %h", {`JM_CNT_W{1'b0}}, jm_cdf_out);
				errs++;
			end
			if (clk_seen && (jm_cdf_valid !== 1'b0)) begin
				$display("ERR jm_cdf_valid exp %h got %h", 1'b0, jm_cdf_valid);
				errs++;
			end
			run = 1'b0;
			gap = 0;
		end else if (!run) begin
			run = 1'b1; // first edge after release, window starts here
			gap = 0;
		end else begin
			gap++;
			if (jm_cdf_valid) begin
				if (gap != WIN) begin
					$display("strobe came %0d cycles after the previous one, not %0d",
						gap, WIN);
					errs++;
				end
				gap = 0;
				if (settled) begin
					diff = int'(jm_cdf_out) - int'(exp_cnt);
					if (diff < 0) begin
						diff = -diff;
					end
					if (diff > tol) begin
						$display("ERR jm_cdf_out exp %h got %h", exp_cnt, jm_cdf_out);
						errs++;
					end
					checks++;
				end
			end else if (gap > WIN) begin
				$display("no strobe within one window plus one cycle of the previous one");
				errs++;
				gap = 0; // report once per missing window
			end
		end
		if (jm_cdf_valid && valid_q) begin
			$display("strobe stayed high for more than one cycle");
			errs++;
		end
		valid_q  = jm_cdf_valid;
		clk_seen = 1'b1;
	end

endmodule

//--- verif/tb_mdll_jmeas.sv
`timescale 1ns/1ps

`include "mdll_config.svh"

module tb_mdll_jmeas import mdll_pkg::*; ();

	// ------------------------------
	// constants
	// ------------------------------

	localparam int          CLK_HALF = 2;  // 4 ns period
	localparam int          RST_CYC  = 16; // en_monitor low at start
	localparam int          WIN      = 1 << `JM_CNT_W;
	localparam int          N_ROWS   = 14;
	localparam int          TIMEOUT_CYC = N_ROWS * 3 * WIN + RST_CYC + 200;
	localparam logic [31:0] SEED     = 32'hcf609ac4;

	localparam logic [`JM_CNT_W-1:0] ALL_ONES = '1;
	localparam logic [`JM_CNT_W-1:0] NONE     = '0;
	localparam logic [`JM_CNT_W-1:0] HALF     = ALL_ONES ^ (ALL_ONES >> 1); // msb only

	// drive modes of the selected input
	localparam logic [1:0] MODE_LO = 2'd0;
	localparam logic [1:0] MODE_HI = 2'd1;
	localparam logic [1:0] MODE_SQ = 2'd2; // toggles every cycle

	typedef struct packed {
		logic [2:0]           sel;     // raw code, 5..7 undefined
		logic                 pol;
		logic [1:0]           mode;
		logic [`JM_CNT_W-1:0] exp_cnt; // expected window count
	} row_t;

	// ------------------------------
	// stimulus table
	// ------------------------------

	localparam row_t STIM [N_ROWS] = '{
		'{3'd0, 1'b1, MODE_HI, ALL_ONES}, // early every cycle, saturates
		'{3'd0, 1'b1, MODE_LO, NONE},
		'{3'd0, 1'b0, MODE_HI, NONE},     // inverted polarity
		'{3'd0, 1'b0, MODE_LO, ALL_ONES},
		'{3'd1, 1'b1, MODE_HI, ALL_ONES}, // osc_90
		'{3'd2, 1'b1, MODE_LO, NONE},     // osc_180
		'{3'd3, 1'b1, MODE_HI, ALL_ONES}, // osc_270
		'{3'd4, 1'b1, MODE_HI, ALL_ONES}, // clk_fb_mon
		'{3'd5, 1'b1, MODE_HI, ALL_ONES}, // undefined codes from here
		'{3'd6, 1'b0, MODE_HI, NONE},
		'{3'd7, 1'b1, MODE_LO, NONE},
		'{3'd1, 1'b1, MODE_SQ, HALF},     // half the window early
		'{3'd4, 1'b0, MODE_SQ, HALF},
		'{3'd2, 1'b1, MODE_SQ, HALF}      // leaves a nonzero result
	};

	// ------------------------------
	// DUT signals
	// ------------------------------

	logic                 clk_monp;
	logic                 en_monitor;
	jm_clk_sel_e          jm_sel_clk;
	logic                 jm_bb_out_pol;
	logic                 osc_0;
	logic                 osc_90;
	logic                 osc_180;
	logic                 osc_270;
	logic                 clk_fb_mon;
	logic                 jm_clk_fb_out;
	logic [`JM_CNT_W-1:0] jm_cdf_out;
	logic                 jm_cdf_valid;

	// testbench state
	logic                 settled;
	logic [`JM_CNT_W-1:0] exp_cnt;
	int                   tol;
	logic [1:0]           cur_mode;
	logic [2:0]           cur_tgt;  // index of the input under test
	logic                 sq_lvl;   // square wave level
	int                   tb_errs;
	int                   chk_errs;
	int                   chk_done;
	int                   cyc = 0;

	always #CLK_HALF clk_monp = ~clk_monp;

	mdll_jmeas i_dut (
		.clk_monp      (clk_monp),
		.en_monitor    (en_monitor),
		.jm_sel_clk    (jm_sel_clk),
		.jm_bb_out_pol (jm_bb_out_pol),
		.osc_0         (osc_0),
		.osc_90        (osc_90),
		.osc_180       (osc_180),
		.osc_270       (osc_270),
		.clk_fb_mon    (clk_fb_mon),
		.jm_clk_fb_out (jm_clk_fb_out),
		.jm_cdf_out    (jm_cdf_out),
		.jm_cdf_valid  (jm_cdf_valid)
	);

	jmeas_checker i_checker (
		.clk_monp      (clk_monp),
		.en_monitor    (en_monitor),
		.clk_fb_mon    (clk_fb_mon),
		.jm_clk_fb_out (jm_clk_fb_out),
		.jm_cdf_out    (jm_cdf_out),
		.jm_cdf_valid  (jm_cdf_valid),
		.settled       (settled),
		.exp_cnt       (exp_cnt),
		.tol           (tol),
		.err_cnt       (chk_errs),
		.n_checked     (chk_done)
	);

	// ------------------------------
	// helpers
	// ------------------------------

	// inputs 0..3 are osc phases, 4 is clk_fb_mon; 5..7 land on osc_180
	function automatic logic [2:0] target_input(input logic [2:0] code);
		if (code > 3'd4) begin
			return 3'd2;
		end
		return code;
	endfunction

	task automatic drive_inputs();
		logic [4:0] lvl;
		lvl = 5'($urandom); // unselected inputs get random levels
		case (cur_mode)
			MODE_LO: lvl[cur_tgt] = 1'b0;
			MODE_HI: lvl[cur_tgt] = 1'b1;
			default: begin
				sq_lvl       = ~sq_lvl;
				lvl[cur_tgt] = sq_lvl;
			end
		endcase
		osc_0      = lvl[0];
		osc_90     = lvl[1];
		osc_180    = lvl[2];
		osc_270    = lvl[3];
		clk_fb_mon = lvl[4];
	endtask

	task automatic next_cycle();
		@(negedge clk_monp);
		drive_inputs();
	endtask

	// returns on the falling edge where the strobe is high
	task automatic wait_strobe();
		do begin
			next_cycle();
		end while (jm_cdf_valid !== 1'b1);
	endtask

	task automatic apply_row(input row_t row);
		@(negedge clk_monp);
		jm_sel_clk    = jm_clk_sel_e'(row.sel);
		jm_bb_out_pol = row.pol;
		cur_mode      = row.mode;
		cur_tgt       = target_input(row.sel);
		drive_inputs();
	endtask

	// two strobes to flush the change, the third is compared
	task automatic run_row(input row_t row);
		apply_row(row);
		wait_strobe();
		wait_strobe();
		next_cycle(); // checker has passed the second strobe
		exp_cnt = row.exp_cnt;
		tol     = (row.mode == MODE_SQ) ? 1 : 0;
		settled = 1'b1;
		wait_strobe();
		next_cycle(); // checker compares at the edge in between
		settled = 1'b0;
	endtask

	// drop en_monitor right on a strobe so both outputs must clear at once
	task automatic clear_midrun();
		wait_strobe();
		en_monitor = 1'b0;
		repeat (4) next_cycle();
		en_monitor = 1'b1;
		wait_strobe(); // checker times this from the release
		next_cycle();
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		clk_monp      = 1'b0;
		en_monitor    = 1'b0;
		jm_sel_clk    = sel_osc_0;
		jm_bb_out_pol = 1'b1;
		osc_0         = 1'b0;
		osc_90        = 1'b0;
		osc_180       = 1'b0;
		osc_270       = 1'b0;
		clk_fb_mon    = 1'b0;
		settled       = 1'b0;
		exp_cnt       = '0;
		tol           = 0;
		cur_mode      = MODE_LO;
		cur_tgt       = 3'd0;
		sq_lvl        = 1'b0;
		tb_errs       = 0;
		void'($urandom(SEED));
		repeat (RST_CYC) next_cycle();
		en_monitor = 1'b1;
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(STIM[r]);
		end
		clear_midrun();
		if (chk_done != N_ROWS) begin
			$display("only %0d of %0d table rows were compared", chk_done, N_ROWS);
			tb_errs++;
		end
		$display("errors: %0d checker, %0d testbench", chk_errs, tb_errs);
		if (chk_errs == 0 && tb_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// ------------------------------
	// timeout
	// ------------------------------

	initial begin
		while (cyc < TIMEOUT_CYC) begin
			@(posedge clk_monp);
			cyc = cyc + 1;
		end
		$display("run stopped after %0d cycles without finishing", TIMEOUT_CYC);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
src/mdll_pkg.sv
src/mdll_jm_sampler.sv
src/mdll_jm_counter.sv
src/mdll_jmeas.sv
verif/jmeas_checker.sv
verif/tb_mdll_jmeas.sv

//--- Makefile
# Verilator flow for the jitter monitor testbench
# run from the project root: make compile, make run, make clean

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	verilator --binary --timing \
		--top-module tb_mdll_jmeas \
		-f build.f \
		-Mdir $(OBJ_DIR) \
		-o sim_tb

# run and decide pass or fail from the log
run: compile
	./$(OBJ_DIR)/sim_tb | tee sim.log
	@if grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) sim.log
